/* verilog/isa_pkg.sv */
// isa_pkg holds the RV32I opcode, funct and ALU operation encodings used by the core
package isa_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	// kind of control transfer resolved in execute
	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_JAL
	} branch_e;

	// funct3 codes of the kept instructions
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL     = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_LW      = 3'b010;
	localparam logic [2:0] F3_SW      = 3'b010;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	// funct7 bit that turns ADD into SUB (instr[30])
	localparam int F7_SUB_BIT = 5;

endpackage

/* verilog/core_pkg.sv */
// core_pkg defines the data widths and the bundles passed between pipeline stages
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;

	// registered output of fetch
	typedef struct packed {
		logic  valid;
		addr_t pc;
		word_t instr;
	} fetch_to_decode_t;

	typedef struct packed {
		logic             valid;
		addr_t            pc;
		isa_pkg::alu_op_e alu_op;
		isa_pkg::branch_e branch;
		word_t            operand_a;
		word_t            operand_b;
		word_t            store_data;
		addr_t            branch_target;
		reg_idx_t         rd;
		logic             rd_we;
		logic             is_load;
		logic             is_store;
	} decode_to_exec_t;

	// result holds the ALU value or the load/store address
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     rd_we;
		word_t    result;
		logic     is_load;
		logic     is_store;
		word_t    store_data;
	} exec_to_mem_t;

	typedef struct packed {
		logic     we;
		reg_idx_t rd;
		word_t    data;
	} reg_write_t;

	typedef struct packed {
		logic  valid;
		addr_t target;
	} redirect_t;

endpackage

/* verilog/fetch_unit.sv */
// fetch_unit keeps the program counter, addresses the ROM and registers the fetched word
`timescale 1ns/100ps

module fetch_unit #(
	parameter core_pkg::addr_t RESET_PC = '0
) (
	input  logic                       sys_clk_i,
	input  logic                       arst_n_i,

	// instruction ROM, read in the same cycle
	output core_pkg::addr_t            rom_addr_o,
	input  core_pkg::word_t            rom_data_i,

	// load-use hold from decode
	input  logic                       stall_i,

	// taken branch or jump from execute
	input  core_pkg::redirect_t        redirect_i,

	output core_pkg::fetch_to_decode_t fetch_o
);

	core_pkg::addr_t pc_q;
	core_pkg::addr_t pc_next;

	// static not-taken, just the next word
	assign pc_next = pc_q + 32'd4;

	assign rom_addr_o = pc_q;

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q    <= RESET_PC;
			fetch_o <= '0;
		end else if (redirect_i.valid) begin
			// the word on the ROM port is on the wrong path
			pc_q          <= redirect_i.target;
			fetch_o.valid <= 1'b0;
		end else if (!stall_i) begin
			pc_q          <= pc_next;
			fetch_o.valid <= 1'b1;
			fetch_o.pc    <= pc_q;
			fetch_o.instr <= rom_data_i;
		end
	end

endmodule

/* verilog/regfile.sv */
// regfile is the 32 x 32 integer register file with two read ports and one write port
`timescale 1ns/100ps

module regfile (
	input  logic                 sys_clk_i,
	input  logic                 arst_n_i,

	// read ports for decode
	input  core_pkg::reg_idx_t   rs1_i,
	input  core_pkg::reg_idx_t   rs2_i,
	output core_pkg::word_t      rs1_data_o,
	output core_pkg::word_t      rs2_data_o,

	// write port from the memory stage
	input  core_pkg::reg_write_t write_i
);

	core_pkg::word_t regs_q [32];

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (write_i.we && write_i.rd != '0) begin
			regs_q[write_i.rd] <= write_i.data;
		end
	end

	// x0 reads as zero
	assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* verilog/decode_unit.sv */
// decode_unit decodes the instruction, builds immediates, forwards operands and detects load-use
`timescale 1ns/100ps

module decode_unit (
	input  core_pkg::fetch_to_decode_t fetch_i,

	// register file read
	output core_pkg::reg_idx_t         rs1_o,
	output core_pkg::reg_idx_t         rs2_o,
	input  core_pkg::word_t            rs1_data_i,
	input  core_pkg::word_t            rs2_data_i,

	// forwarding sources, execute first
	input  core_pkg::reg_write_t       ex_fwd_i,
	input  core_pkg::reg_write_t       wb_fwd_i,

	// load sitting in execute
	input  logic                       ex_is_load_i,
	input  core_pkg::reg_idx_t         ex_rd_i,

	output core_pkg::decode_to_exec_t  decoded_o,
	output logic                       stall_o
);

	core_pkg::word_t    instr;
	isa_pkg::opcode_e   opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	core_pkg::reg_idx_t rd;
	core_pkg::word_t    imm_i;
	core_pkg::word_t    imm_s;
	core_pkg::word_t    imm_b;
	core_pkg::word_t    imm_j;
	core_pkg::word_t    imm_u;
	core_pkg::word_t    rs1_val;
	core_pkg::word_t    rs2_val;
	core_pkg::word_t    op_b;
	core_pkg::addr_t    target;
	isa_pkg::alu_op_e   alu_op;
	isa_pkg::branch_e   branch;
	logic               known;
	logic               uses_rs1;
	logic               uses_rs2;
	logic               rd_we;
	logic               is_load;
	logic               is_store;

	// newest producer wins, x0 is never forwarded
	function automatic core_pkg::word_t pick_operand(
		input core_pkg::reg_idx_t   idx,
		input core_pkg::word_t      rf_val,
		input core_pkg::reg_write_t ex_src,
		input core_pkg::reg_write_t wb_src
	);
		core_pkg::word_t val;
		val = rf_val;
		if (idx != '0) begin
			if (ex_src.we && ex_src.rd == idx) begin
				val = ex_src.data;
			end else if (wb_src.we && wb_src.rd == idx) begin
				val = wb_src.data;
			end
		end
		return val;
	endfunction

	assign instr  = fetch_i.instr;
	assign opcode = isa_pkg::opcode_e'(instr[6:0]);
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1_o  = instr[19:15];
	assign rs2_o  = instr[24:20];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	assign rs1_val = pick_operand(rs1_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
	assign rs2_val = pick_operand(rs2_o, rs2_data_i, ex_fwd_i, wb_fwd_i);

	always_comb begin
		known    = 1'b1;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		rd_we    = 1'b0;
		is_load  = 1'b0;
		is_store = 1'b0;
		alu_op   = isa_pkg::ALU_ADD;
		branch   = isa_pkg::BR_NONE;
		op_b     = imm_i;
		target   = fetch_i.pc + imm_b;
		case (opcode)
			isa_pkg::OPC_OP: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				rd_we    = 1'b1;
				op_b     = rs2_val;
				case (funct3)
					isa_pkg::F3_ADD_SUB: begin
						alu_op = funct7[isa_pkg::F7_SUB_BIT] ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
					end
					isa_pkg::F3_SLL: alu_op = isa_pkg::ALU_SLL;
					isa_pkg::F3_SLT: alu_op = isa_pkg::ALU_SLT;
					isa_pkg::F3_XOR: alu_op = isa_pkg::ALU_XOR;
					// SRA is not supported
					isa_pkg::F3_SRL: begin
						alu_op = isa_pkg::ALU_SRL;
						known  = !funct7[isa_pkg::F7_SUB_BIT];
					end
					isa_pkg::F3_OR:  alu_op = isa_pkg::ALU_OR;
					isa_pkg::F3_AND: alu_op = isa_pkg::ALU_AND;
					default:         known  = 1'b0;
				endcase
			end
			isa_pkg::OPC_OP_IMM: begin
				uses_rs1 = 1'b1;
				rd_we    = 1'b1;
				case (funct3)
					isa_pkg::F3_ADD_SUB: alu_op = isa_pkg::ALU_ADD;
					isa_pkg::F3_SLT:     alu_op = isa_pkg::ALU_SLT;
					isa_pkg::F3_XOR:     alu_op = isa_pkg::ALU_XOR;
					isa_pkg::F3_OR:      alu_op = isa_pkg::ALU_OR;
					isa_pkg::F3_AND:     alu_op = isa_pkg::ALU_AND;
					default:             known  = 1'b0;
				endcase
			end
			isa_pkg::OPC_LUI: begin
				rd_we  = 1'b1;
				alu_op = isa_pkg::ALU_PASS_B;
				op_b   = imm_u;
			end
			isa_pkg::OPC_LOAD: begin
				uses_rs1 = 1'b1;
				rd_we    = 1'b1;
				is_load  = 1'b1;
				known    = (funct3 == isa_pkg::F3_LW);
			end
			isa_pkg::OPC_STORE: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				is_store = 1'b1;
				op_b     = imm_s;
				known    = (funct3 == isa_pkg::F3_SW);
			end
			isa_pkg::OPC_BRANCH: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				op_b     = rs2_val;
				case (funct3)
					isa_pkg::F3_BEQ: branch = isa_pkg::BR_BEQ;
					isa_pkg::F3_BNE: branch = isa_pkg::BR_BNE;
					default:         known  = 1'b0;
				endcase
			end
			isa_pkg::OPC_JAL: begin
				rd_we  = 1'b1;
				branch = isa_pkg::BR_JAL;
				target = fetch_i.pc + imm_j;
			end
			default: known = 1'b0;
		endcase
	end

	// hold one cycle while a load in execute produces an operand we need
	assign stall_o = fetch_i.valid && known && ex_is_load_i && (ex_rd_i != '0) &&
		((uses_rs1 && rs1_o == ex_rd_i) || (uses_rs2 && rs2_o == ex_rd_i));

	always_comb begin
		decoded_o.valid         = fetch_i.valid && known && !stall_o;
		decoded_o.pc            = fetch_i.pc;
		decoded_o.alu_op        = alu_op;
		decoded_o.branch        = known ? branch : isa_pkg::BR_NONE;
		decoded_o.operand_a     = rs1_val;
		decoded_o.operand_b     = op_b;
		decoded_o.store_data    = rs2_val;
		decoded_o.branch_target = target;
		decoded_o.rd            = rd;
		decoded_o.rd_we         = rd_we && known;
		decoded_o.is_load       = is_load && known;
		decoded_o.is_store      = is_store && known;
	end

endmodule

/* verilog/execute_unit.sv */
// execute_unit registers the decoded instruction, runs the ALU and resolves branches and JAL
`timescale 1ns/100ps

module execute_unit (
	input  logic                      sys_clk_i,
	input  logic                      arst_n_i,

	input  core_pkg::decode_to_exec_t decoded_i,

	// towards the memory stage
	output core_pkg::exec_to_mem_t    to_mem_o,

	// back to decode
	output core_pkg::reg_write_t      ex_fwd_o,
	output logic                      ex_is_load_o,
	output core_pkg::reg_idx_t        ex_rd_o,

	// to fetch
	output core_pkg::redirect_t       redirect_o
);

	core_pkg::decode_to_exec_t ex_q;
	core_pkg::word_t           alu_res;
	core_pkg::word_t           result;
	logic                      operands_eq;
	logic                      taken;

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_q <= '0;
		end else if (redirect_o.valid) begin
			// squash the wrong-path instruction sitting in decode
			ex_q <= '0;
		end else begin
			ex_q <= decoded_i;
		end
	end

	always_comb begin
		unique case (ex_q.alu_op)
			isa_pkg::ALU_ADD:    alu_res = ex_q.operand_a + ex_q.operand_b;
			isa_pkg::ALU_SUB:    alu_res = ex_q.operand_a - ex_q.operand_b;
			isa_pkg::ALU_AND:    alu_res = ex_q.operand_a & ex_q.operand_b;
			isa_pkg::ALU_OR:     alu_res = ex_q.operand_a | ex_q.operand_b;
			isa_pkg::ALU_XOR:    alu_res = ex_q.operand_a ^ ex_q.operand_b;
			isa_pkg::ALU_SLT: begin
				alu_res = {31'b0, $signed(ex_q.operand_a) < $signed(ex_q.operand_b)};
			end
			isa_pkg::ALU_SLL:    alu_res = ex_q.operand_a << ex_q.operand_b[4:0];
			isa_pkg::ALU_SRL:    alu_res = ex_q.operand_a >> ex_q.operand_b[4:0];
			isa_pkg::ALU_PASS_B: alu_res = ex_q.operand_b;
			default:             alu_res = '0;
		endcase
	end

	// link value for JAL
	assign result = (ex_q.branch == isa_pkg::BR_JAL) ? ex_q.pc + 32'd4 : alu_res;

	assign operands_eq = (ex_q.operand_a == ex_q.operand_b);

	always_comb begin
		unique case (ex_q.branch)
			isa_pkg::BR_BEQ: taken = operands_eq;
			isa_pkg::BR_BNE: taken = !operands_eq;
			isa_pkg::BR_JAL: taken = 1'b1;
			default:         taken = 1'b0;
		endcase
	end

	assign redirect_o.valid  = ex_q.valid && taken;
	assign redirect_o.target = ex_q.branch_target;

	assign to_mem_o.valid      = ex_q.valid;
	assign to_mem_o.rd         = ex_q.rd;
	assign to_mem_o.rd_we      = ex_q.rd_we;
	assign to_mem_o.result     = result;
	assign to_mem_o.is_load    = ex_q.is_load;
	assign to_mem_o.is_store   = ex_q.is_store;
	assign to_mem_o.store_data = ex_q.store_data;

	// load data is not ready yet, decode stalls on it instead
	assign ex_fwd_o.we   = ex_q.valid && ex_q.rd_we && !ex_q.is_load;
	assign ex_fwd_o.rd   = ex_q.rd;
	assign ex_fwd_o.data = result;

	assign ex_is_load_o = ex_q.valid && ex_q.is_load;
	assign ex_rd_o      = ex_q.rd;

endmodule

/* verilog/mem_wb_unit.sv */
// mem_wb_unit registers the execute result, drives the data RAM and produces the register write
`timescale 1ns/100ps

module mem_wb_unit (
	input  logic                   sys_clk_i,
	input  logic                   arst_n_i,

	input  core_pkg::exec_to_mem_t from_ex_i,

	// data RAM, word access only
	output logic                   ram_ce_o,
	output logic                   ram_we_o,
	output core_pkg::addr_t        ram_addr_o,
	output core_pkg::word_t        ram_data_o,
	input  core_pkg::word_t        ram_data_i,

	// register file write, also forwarded to decode
	output core_pkg::reg_write_t   write_o
);

	core_pkg::exec_to_mem_t mem_q;

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_q <= '0;
		end else begin
			mem_q <= from_ex_i;
		end
	end

	assign ram_ce_o   = mem_q.valid && (mem_q.is_load || mem_q.is_store);
	assign ram_we_o   = mem_q.valid && mem_q.is_store;
	assign ram_addr_o = mem_q.result;
	assign ram_data_o = mem_q.store_data;

	// RAM answers in the same cycle
	assign write_o.we   = mem_q.valid && mem_q.rd_we;
	assign write_o.rd   = mem_q.rd;
	assign write_o.data = mem_q.is_load ? ram_data_i : mem_q.result;

endmodule

/* verilog/core_top.sv */
// core_top connects the four pipeline stages and the register file of the RV32I core
`timescale 1ns/100ps

module core_top #(
	parameter core_pkg::addr_t RESET_PC = '0
) (
	input  logic            sys_clk_i,
	input  logic            arst_n_i,

	// instruction ROM
	output core_pkg::addr_t rom_addr_o,
	input  core_pkg::word_t rom_data_i,

	// data RAM
	output logic            ram_ce_o,
	output logic            ram_we_o,
	output core_pkg::addr_t ram_addr_o,
	output core_pkg::word_t ram_data_o,
	input  core_pkg::word_t ram_data_i
);

	core_pkg::fetch_to_decode_t fetch_to_decode;
	core_pkg::decode_to_exec_t  decode_to_exec;
	core_pkg::exec_to_mem_t     exec_to_mem;
	core_pkg::redirect_t        redirect;
	core_pkg::reg_write_t       ex_fwd;
	core_pkg::reg_write_t       wb_write;
	core_pkg::reg_idx_t         rs1_idx;
	core_pkg::reg_idx_t         rs2_idx;
	core_pkg::word_t            rs1_data;
	core_pkg::word_t            rs2_data;
	core_pkg::reg_idx_t         ex_rd;
	logic                       ex_is_load;
	logic                       stall;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch_unit_inst (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.rom_addr_o(rom_addr_o),
		.rom_data_i(rom_data_i),
		.stall_i(stall),
		.redirect_i(redirect),
		.fetch_o(fetch_to_decode)
	);

	decode_unit decode_unit_inst (
		.fetch_i(fetch_to_decode),
		.rs1_o(rs1_idx),
		.rs2_o(rs2_idx),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.ex_fwd_i(ex_fwd),
		.wb_fwd_i(wb_write),
		.ex_is_load_i(ex_is_load),
		.ex_rd_i(ex_rd),
		.decoded_o(decode_to_exec),
		.stall_o(stall)
	);

	regfile regfile_inst (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.rs1_i(rs1_idx),
		.rs2_i(rs2_idx),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.write_i(wb_write)
	);

	execute_unit execute_unit_inst (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.decoded_i(decode_to_exec),
		.to_mem_o(exec_to_mem),
		.ex_fwd_o(ex_fwd),
		.ex_is_load_o(ex_is_load),
		.ex_rd_o(ex_rd),
		.redirect_o(redirect)
	);

	mem_wb_unit mem_wb_unit_inst (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.from_ex_i(exec_to_mem),
		.ram_ce_o(ram_ce_o),
		.ram_we_o(ram_we_o),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_data_i(ram_data_i),
		.write_o(wb_write)
	);

endmodule

/* tb/core_top_asserts.sv */
// core_top_asserts checks the RAM strobes and the ROM address at the core ports
`timescale 1ns/100ps

module core_top_asserts (
	input logic            sys_clk_i,
	input logic            arst_n_i,
	input core_pkg::addr_t rom_addr_i,
	input logic            ram_ce_i,
	input logic            ram_we_i
);

	// a write is always an access too
	we_implies_ce: assert property (
		@(posedge sys_clk_i) disable iff (!arst_n_i) ram_we_i |-> ram_ce_i
	) else $error("ram_we_o high while ram_ce_o is low");

	// pipeline is empty right after reset
	quiet_after_reset: assert property (
		@(posedge sys_clk_i) $rose(arst_n_i) |-> (!ram_ce_i && !ram_we_i)
	) else $error("RAM strobes active in the first cycle after reset");

	rom_word_aligned: assert property (
		@(posedge sys_clk_i) rom_addr_i[1:0] == 2'b00
	) else $error("rom_addr_o is not word aligned");

endmodule

/* tb/core_top_tb.sv */
// core_top_tb runs short RV32I programs on the core and checks every store it makes
`timescale 1ns/100ps

module core_top_tb;

	localparam core_pkg::addr_t RESET_PC = '0;
	localparam int NUM_CASES = 5;
	localparam int PROG_WORDS = 16;
	localparam int MAX_STORES = 6;
	localparam int MEM_WORDS = 64;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int OPC_IMM = 'h13;
	localparam int OPC_LOAD = 'h03;
	localparam core_pkg::word_t NOP = 32'h0000_0013;

	typedef struct packed {
		core_pkg::addr_t addr;
		core_pkg::word_t data;
	} store_t;

	logic            sys_clk;
	logic            arst_n;
	core_pkg::addr_t rom_addr;
	core_pkg::word_t rom_data;
	logic            ram_ce;
	logic            ram_we;
	core_pkg::addr_t ram_addr;
	core_pkg::word_t ram_wdata;
	core_pkg::word_t ram_rdata;

	core_pkg::word_t rom [MEM_WORDS];
	core_pkg::word_t ram [MEM_WORDS];

	// stores seen on the RAM port in arrival order
	store_t          store_q [$];
	int              store_total;

	string           case_name [NUM_CASES];
	core_pkg::word_t prog [NUM_CASES][PROG_WORDS];
	int              prog_len [NUM_CASES];
	store_t          exp_store [NUM_CASES][MAX_STORES];
	int              exp_count [NUM_CASES];

	core_top #(
		.RESET_PC(RESET_PC)
	) core_top_inst (
		.sys_clk_i(sys_clk),
		.arst_n_i(arst_n),
		.rom_addr_o(rom_addr),
		.rom_data_i(rom_data),
		.ram_ce_o(ram_ce),
		.ram_we_o(ram_we),
		.ram_addr_o(ram_addr),
		.ram_data_o(ram_wdata),
		.ram_data_i(ram_rdata)
	);

	bind core_top core_top_asserts core_top_asserts_inst (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.rom_addr_i(rom_addr_o),
		.ram_ce_i(ram_ce_o),
		.ram_we_i(ram_we_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// ROM and RAM read combinationally
	assign rom_data  = rom[rom_addr[7:2]];
	assign ram_rdata = ram[ram_addr[7:2]];

	// memory stage outputs are settled at mid-cycle
	always @(negedge sys_clk) begin
		if (ram_ce && ram_we) begin
			ram[ram_addr[7:2]] = ram_wdata;
			store_q.push_back({ram_addr, ram_wdata});
			store_total++;
		end else if (ram_ce && store_total == 0) begin
			report_failure($sformatf("RAM read from %h before the first store", ram_addr));
		end
	end

	function automatic core_pkg::word_t r_format(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic core_pkg::word_t i_format(input int opc, input int f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	// always a word store
	function automatic core_pkg::word_t s_format(input int rs1, input int rs2, input int offset);
		return {offset[11:5], rs2[4:0], rs1[4:0], 3'b010, offset[4:0], 7'b0100011};
	endfunction

	function automatic core_pkg::word_t b_format(input int f3, input int rs1, input int rs2,
		input int offset);
		logic [12:0] imm;
		imm = offset[12:0];
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic core_pkg::word_t u_format(input int rd, input int upper);
		return {upper[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic core_pkg::word_t j_format(input int rd, input int offset);
		logic [20:0] imm;
		imm = offset[20:0];
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic void add_instr(input int c, input core_pkg::word_t instr);
		prog[c][prog_len[c]] = instr;
		prog_len[c]++;
	endfunction

	function automatic void expect_store(input int c, input core_pkg::addr_t addr,
		input core_pkg::word_t data);
		exp_store[c][exp_count[c]] = {addr, data};
		exp_count[c]++;
	endfunction

	task automatic build_table();
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t v;
		// each result feeds the very next instruction
		case_name[0] = "forwarding";
		add_instr(0, i_format(OPC_IMM, 0, 1, 0, 37));
		add_instr(0, r_format(0, 0, 2, 1, 1));
		add_instr(0, r_format('h20, 0, 3, 1, 2));
		add_instr(0, r_format(0, 4, 4, 3, 2));
		add_instr(0, s_format(0, 4, 'h40));
		add_instr(0, j_format(0, 0));
		a = 32'd37 + 32'd37;
		b = 32'd37 - a;
		expect_store(0, 'h40, b ^ a);
		case_name[1] = "immediates";
		add_instr(1, u_format(1, 'h12345));
		add_instr(1, i_format(OPC_IMM, 6, 2, 1, 'h678));
		add_instr(1, i_format(OPC_IMM, 0, 3, 0, 4));
		add_instr(1, r_format(0, 1, 4, 2, 3));
		add_instr(1, r_format(0, 5, 5, 2, 3));
		add_instr(1, i_format(OPC_IMM, 0, 6, 0, -3));
		add_instr(1, r_format(0, 2, 7, 6, 3));
		add_instr(1, i_format(OPC_IMM, 2, 8, 3, -1));
		add_instr(1, s_format(0, 1, 'h40));
		add_instr(1, s_format(0, 2, 'h44));
		add_instr(1, s_format(0, 4, 'h48));
		add_instr(1, s_format(0, 5, 'h4c));
		add_instr(1, s_format(0, 7, 'h50));
		add_instr(1, s_format(0, 8, 'h54));
		add_instr(1, j_format(0, 0));
		v = 32'h12345 << 12;
		expect_store(1, 'h40, v);
		v = v | 32'h678;
		expect_store(1, 'h44, v);
		expect_store(1, 'h48, v << 4);
		expect_store(1, 'h4c, v >> 4);
		expect_store(1, 'h50, (-3 < 4) ? 32'd1 : 32'd0);
		expect_store(1, 'h54, (4 < -1) ? 32'd1 : 32'd0);
		// loaded value used by the next instruction
		case_name[2] = "load_use";
		add_instr(2, i_format(OPC_IMM, 0, 1, 0, 'h123));
		add_instr(2, s_format(0, 1, 'h60));
		add_instr(2, i_format(OPC_LOAD, 2, 2, 0, 'h60));
		add_instr(2, i_format(OPC_IMM, 0, 3, 2, 45));
		add_instr(2, s_format(0, 3, 'h64));
		add_instr(2, j_format(0, 0));
		expect_store(2, 'h60, 32'h123);
		expect_store(2, 'h64, 32'h123 + 32'd45);
		// marker stores in the shadow of the BEQ must never show up
		case_name[3] = "taken_branch";
		add_instr(3, i_format(OPC_IMM, 0, 1, 0, 9));
		add_instr(3, i_format(OPC_IMM, 0, 2, 0, 9));
		add_instr(3, i_format(OPC_IMM, 0, 3, 0, 'hba));
		add_instr(3, b_format(0, 1, 2, 12));
		add_instr(3, s_format(0, 3, 'h70));
		add_instr(3, s_format(0, 3, 'h74));
		add_instr(3, r_format(0, 0, 4, 1, 2));
		add_instr(3, s_format(0, 4, 'h78));
		add_instr(3, j_format(0, 0));
		expect_store(3, 'h78, 32'd9 + 32'd9);
		// BNE falls through and the JAL at word 5 skips one store
		case_name[4] = "bne_jal";
		add_instr(4, i_format(OPC_IMM, 0, 1, 0, 3));
		add_instr(4, i_format(OPC_IMM, 0, 2, 0, 3));
		add_instr(4, i_format(OPC_IMM, 0, 3, 0, 'h55));
		add_instr(4, b_format(1, 1, 2, 8));
		add_instr(4, s_format(0, 3, 'h80));
		add_instr(4, j_format(5, 8));
		add_instr(4, s_format(0, 3, 'h84));
		add_instr(4, s_format(0, 5, 'h88));
		add_instr(4, j_format(0, 0));
		expect_store(4, 'h80, 32'h55);
		expect_store(4, 'h88, RESET_PC + 32'd20 + 32'd4);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input core_pkg::word_t expected,
		input core_pkg::word_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input core_pkg::addr_t expected,
		input core_pkg::addr_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic wait_store(input string name);
		int cycles;
		cycles = 0;
		while (store_q.size() == 0) begin
			if (cycles == TIMEOUT_CYCLES) begin
				report_failure($sformatf("%s: no store within %0d cycles", name, TIMEOUT_CYCLES));
			end
			@(posedge sys_clk);
			cycles++;
		end
	endtask

	// program words followed by random filler past the final self-jump
	task automatic load_memories(input int c);
		core_pkg::word_t filler;
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < prog_len[c]) begin
				rom[i] = prog[c][i];
			end else begin
				filler = $urandom();
				rom[i] = (filler == NOP) ? ~filler : filler;
			end
			ram[i] = 32'hd00d_0000 ^ (i * 4);
		end
	endtask

	task automatic run_case(input int c);
		store_t got;
		@(posedge sys_clk);
		#10;
		arst_n = 1'b0;
		load_memories(c);
		store_q.delete();
		store_total = 0;
		repeat (2) @(posedge sys_clk);
		#10;
		arst_n = 1'b1;
		check_addr($sformatf("%s reset pc", case_name[c]), RESET_PC, rom_addr);
		for (int k = 0; k < exp_count[c]; k++) begin
			wait_store(case_name[c]);
			got = store_q.pop_front();
			check_addr($sformatf("%s store %0d addr", case_name[c], k), exp_store[c][k].addr,
				got.addr);
			check_word($sformatf("%s store %0d data", case_name[c], k), exp_store[c][k].data,
				got.data);
		end
		// the program now spins on its self-jump
		repeat (8) begin
			@(posedge sys_clk);
			if (store_q.size() != 0) begin
				report_failure($sformatf("%s: unexpected store of %h to %h", case_name[c],
					store_q[0].data, store_q[0].addr));
			end
		end
	endtask

	initial begin
		arst_n = 1'b0;
		store_total = 0;
		void'($urandom(32'h4ecb));
		for (int i = 0; i < MEM_WORDS; i++) begin
			rom[i] = NOP;
			ram[i] = '0;
		end
		build_table();
		for (int c = 0; c < NUM_CASES; c++) begin
			run_case(c);
		end
		$display("test passed");
		$finish;
	end

endmodule

/* core_top.f */
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_wb_unit.sv
verilog/core_top.sv
tb/core_top_asserts.sv
tb/core_top_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps \
	--top-module core_top_tb \
	-f core_top.f \
	-o core_top_tb_sim
./obj_dir/core_top_tb_sim
